// File: rv_macros.svh
`ifndef RV_MACROS_SVH
`define RV_MACROS_SVH

// data and word-address width
`define RV_XLEN 32

// register index width for 32 entries
`define RV_REG_AW 5

// shift amount taken from the low bits of operand b
`define RV_SHAMT_W 5

// word index of the first fetch
`define RV_RESET_PC 32'h0000_0000

// all-ones major opcode stops the core
`define RV_HALT_OPCODE 7'b111_1111

`endif

// File: rvPkg.sv
`include "rv_macros.svh"

package rvPkg;

   // major opcodes of the supported subset
   typedef enum logic [6:0] {
      opOpImm = 7'b001_0011,
      opLui   = 7'b011_0111,
      opOp    = 7'b011_0011,
      opStore = 7'b010_0011,
      opLoad  = 7'b000_0011,
      opHalt  = `RV_HALT_OPCODE
   } opcodeE;

   typedef enum logic [3:0] {
      aluAdd,
      aluSub,
      aluXor,
      aluOr,
      aluAnd,
      aluSll,
      aluSrl,
      aluSra,
      aluSlt,     // signed compare
      aluPassB    // operand b straight through for lui
   } aluOpE;

endpackage

// File: regFile.sv
`timescale 1ns/100ps
`include "rv_macros.svh"

module regFile (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic [`RV_REG_AW-1:0] rs1,
   input  logic [`RV_REG_AW-1:0] rs2,
   input  logic                  wEn,
   input  logic [`RV_REG_AW-1:0] wAddr,
   input  logic [`RV_XLEN-1:0]   wData,
   output logic [`RV_XLEN-1:0]   rs1Data,
   output logic [`RV_XLEN-1:0]   rs2Data
);

   localparam int NumRegs = 2 ** `RV_REG_AW;

   logic [`RV_XLEN-1:0] regs [NumRegs];

   always_ff @(posedge clk) begin
      if (!rstn) begin
         for (int i = 0; i < NumRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (wEn && (wAddr != '0)) begin   // x0 writes dropped
         regs[wAddr] <= wData;
      end
   end

   assign rs1Data = regs[rs1];
   assign rs2Data = regs[rs2];

   property pZeroReg;
      @(posedge clk) disable iff (!rstn)
         ((rs1 == '0) |-> (rs1Data == '0)) and ((rs2 == '0) |-> (rs2Data == '0));
   endproperty

   aZeroReg: assert property (pZeroReg);

endmodule

// File: intAlu.sv
`timescale 1ns/100ps
`include "rv_macros.svh"

module intAlu (
   input  logic [`RV_XLEN-1:0] rs1Data,
   input  logic [`RV_XLEN-1:0] rs2Data,
   input  logic [`RV_XLEN-1:0] imm,
   input  logic                useImm,
   input  rvPkg::aluOpE        aluOp,
   output logic [`RV_XLEN-1:0] result
);

   logic [`RV_XLEN-1:0]    opB;
   logic [`RV_SHAMT_W-1:0] shamt;
   logic                   lessThan;

   assign opB      = useImm ? imm : rs2Data;
   assign shamt    = opB[`RV_SHAMT_W-1:0];
   assign lessThan = $signed(rs1Data) < $signed(opB);

   always_comb begin
      case (aluOp)
         rvPkg::aluAdd:   result = rs1Data + opB;
         rvPkg::aluSub:   result = rs1Data - opB;
         rvPkg::aluXor:   result = rs1Data ^ opB;
         rvPkg::aluOr:    result = rs1Data | opB;
         rvPkg::aluAnd:   result = rs1Data & opB;
         rvPkg::aluSll:   result = rs1Data << shamt;
         rvPkg::aluSrl:   result = rs1Data >> shamt;
         rvPkg::aluSra:   result = $signed(rs1Data) >>> shamt;
         rvPkg::aluSlt:   result = {{(`RV_XLEN-1){1'b0}}, lessThan};
         rvPkg::aluPassB: result = opB;
         default:         result = '0;
      endcase
   end

endmodule

// File: instrDecoder.sv
`timescale 1ns/100ps
`include "rv_macros.svh"

module instrDecoder (
   input  logic [`RV_XLEN-1:0]   instr,
   output logic [`RV_REG_AW-1:0] rs1,
   output logic [`RV_REG_AW-1:0] rs2,
   output logic [`RV_REG_AW-1:0] rd,
   output logic [`RV_XLEN-1:0]   imm,
   output logic                  useImm,
   output rvPkg::aluOpE          aluOp,
   output logic                  writesRd,
   output logic                  isLoad,
   output logic                  isStore,
   output logic                  isHalt,
   output logic                  illegal
);

   logic [2:0]          funct3;
   logic [6:0]          funct7;
   logic [`RV_XLEN-1:0] immI;
   logic [`RV_XLEN-1:0] immS;
   logic [`RV_XLEN-1:0] immU;

   assign rd     = instr[11:7];
   assign funct3 = instr[14:12];
   assign rs1    = instr[19:15];
   assign rs2    = instr[24:20];
   assign funct7 = instr[31:25];

   assign immI = {{(`RV_XLEN-12){instr[31]}}, instr[31:20]};
   assign immS = {{(`RV_XLEN-12){instr[31]}}, instr[31:25], instr[11:7]};
   assign immU = {instr[31:12], 12'h000};   // already shifted for lui

   always_comb begin
      imm      = immI;
      useImm   = 1'b1;
      aluOp    = rvPkg::aluAdd;   // loads and stores add the offset
      writesRd = 1'b0;
      isLoad   = 1'b0;
      isStore  = 1'b0;
      isHalt   = 1'b0;
      illegal  = 1'b0;

      case (rvPkg::opcodeE'(instr[6:0]))
         rvPkg::opOpImm: begin
            writesRd = 1'b1;
            case (funct3)
               3'b000: aluOp = rvPkg::aluAdd;
               3'b010: aluOp = rvPkg::aluSlt;
               3'b100: aluOp = rvPkg::aluXor;
               3'b110: aluOp = rvPkg::aluOr;
               3'b111: aluOp = rvPkg::aluAnd;
               3'b001: begin
                  aluOp   = rvPkg::aluSll;
                  illegal = (funct7 != 7'b000_0000);
               end
               3'b101: begin
                  if (funct7 == 7'b000_0000) begin
                     aluOp = rvPkg::aluSrl;
                  end else if (funct7 == 7'b010_0000) begin
                     aluOp = rvPkg::aluSra;
                  end else begin
                     illegal = 1'b1;
                  end
               end
               default: illegal = 1'b1;   // sltiu
            endcase
         end
         rvPkg::opLui: begin
            imm      = immU;
            aluOp    = rvPkg::aluPassB;
            writesRd = 1'b1;
         end
         rvPkg::opOp: begin
            useImm   = 1'b0;
            writesRd = 1'b1;
            if (funct7 == 7'b010_0000 && funct3 == 3'b000) begin
               aluOp = rvPkg::aluSub;
            end else if (funct7 == 7'b000_0000) begin
               case (funct3)
                  3'b000:  aluOp = rvPkg::aluAdd;
                  3'b100:  aluOp = rvPkg::aluXor;
                  3'b110:  aluOp = rvPkg::aluOr;
                  3'b111:  aluOp = rvPkg::aluAnd;
                  3'b001:  aluOp = rvPkg::aluSll;
                  default: illegal = 1'b1;
               endcase
            end else begin
               illegal = 1'b1;
            end
         end
         rvPkg::opStore: begin
            imm     = immS;
            isStore = 1'b1;
            illegal = (funct3 != 3'b010);   // word only
         end
         rvPkg::opLoad: begin
            isLoad   = 1'b1;
            writesRd = 1'b1;
            illegal  = (funct3 != 3'b010);
         end
         rvPkg::opHalt: isHalt = 1'b1;
         default:       illegal = 1'b1;
      endcase

      // an illegal word must not touch registers or memory
      if (illegal) begin
         writesRd = 1'b0;
         isLoad   = 1'b0;
         isStore  = 1'b0;
      end
   end

endmodule

// File: coreSequencer.sv
`timescale 1ns/100ps
`include "rv_macros.svh"

module coreSequencer (
   input  logic                  clk,
   input  logic                  rstn,
   input  logic                  memVld,
   input  logic [`RV_XLEN-1:0]   memRData,
   input  logic                  launch,
   input  logic [`RV_REG_AW-1:0] rd,
   input  logic                  writesRd,
   input  logic                  isLoad,
   input  logic                  isStore,
   input  logic                  isHalt,
   input  logic                  illegal,
   input  logic [`RV_XLEN-1:0]   aluResult,
   input  logic [`RV_XLEN-1:0]   rs2Data,
   output logic                  memReq,
   output logic [`RV_XLEN-1:0]   memAddr,
   output logic                  memWEn,
   output logic [`RV_XLEN-1:0]   memWData,
   output logic                  halt,
   output logic [`RV_XLEN-1:0]   instr,
   output logic                  rfWEn,
   output logic [`RV_REG_AW-1:0] rfWAddr,
   output logic [`RV_XLEN-1:0]   rfWData
);

   typedef enum logic [1:0] {
      sIdle,
      sFetch,
      sExecute,
      sMem
   } stateE;

   stateE               state;
   logic [`RV_XLEN-1:0] pc;
   logic                memDone;
   logic                memOp;

   assign memDone = memReq && memVld;
   assign memOp   = isLoad || isStore;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         state  <= sIdle;
         halt   <= 1'b1;
         memReq <= 1'b0;
         memWEn <= 1'b0;
         pc     <= `RV_RESET_PC;
      end else begin
         case (state)
            sIdle: begin
               if (halt && launch) begin
                  halt   <= 1'b0;
                  memReq <= 1'b1;   // fetch at pc
                  state  <= sFetch;
               end
            end
            sFetch: begin
               if (memDone) begin
                  memReq <= 1'b0;
                  state  <= sExecute;
               end
            end
            sExecute: begin
               pc <= pc + 1'b1;
               if (isHalt || illegal) begin
                  halt  <= 1'b1;
                  state <= sIdle;
               end else if (memOp) begin
                  memReq <= 1'b1;
                  memWEn <= isStore;
                  state  <= sMem;
               end else begin
                  memReq <= 1'b1;
                  state  <= sFetch;
               end
            end
            sMem: begin
               // request stays up for the following fetch
               if (memDone) begin
                  memWEn <= 1'b0;
                  state  <= sFetch;
               end
            end
            default: state <= sIdle;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (state == sIdle) begin
         memAddr <= pc;
      end else if (state == sExecute) begin
         if (memOp) begin
            memAddr  <= aluResult;
            memWData <= rs2Data;
         end else begin
            memAddr <= pc + 1'b1;
         end
      end else if (state == sMem && memDone) begin
         memAddr <= pc;   // pc already past the load or store
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         instr <= '0;
      end else if (state == sFetch && memDone) begin
         instr <= memRData;
      end
   end

   // alu results in execute, load data when the read completes
   assign rfWEn   = (state == sExecute && writesRd && !isLoad) ||
                    (state == sMem && memDone && writesRd && isLoad);
   assign rfWAddr = rd;
   assign rfWData = (state == sMem) ? memRData : aluResult;

   property pReqHold;
      @(posedge clk) disable iff (!rstn)
         (memReq && !memVld) |=> (memReq && $stable(memAddr) && $stable(memWEn) &&
                                  (!memWEn || $stable(memWData)));
   endproperty

   aReqHold: assert property (pReqHold);
   aWEnReq:  assert property (@(posedge clk) disable iff (!rstn) memWEn |-> memReq);

endmodule

// File: rvCore.sv
`timescale 1ns/100ps
`include "rv_macros.svh"

module rvCore (
   input  logic                clk,
   input  logic                rstn,
   output logic                memReq,
   output logic [`RV_XLEN-1:0] memAddr,
   output logic                memWEn,
   output logic [`RV_XLEN-1:0] memWData,
   input  logic                memVld,
   input  logic [`RV_XLEN-1:0] memRData,
   output logic                halt,
   input  logic                launch
);

   logic [`RV_XLEN-1:0]   instr;
   logic [`RV_REG_AW-1:0] rs1;
   logic [`RV_REG_AW-1:0] rs2;
   logic [`RV_REG_AW-1:0] rd;
   logic [`RV_XLEN-1:0]   imm;
   logic                  useImm;
   rvPkg::aluOpE          aluOp;
   logic                  writesRd;
   logic                  isLoad;
   logic                  isStore;
   logic                  isHalt;
   logic                  illegal;
   logic [`RV_XLEN-1:0]   rs1Data;
   logic [`RV_XLEN-1:0]   rs2Data;
   logic [`RV_XLEN-1:0]   aluResult;
   logic                  rfWEn;
   logic [`RV_REG_AW-1:0] rfWAddr;
   logic [`RV_XLEN-1:0]   rfWData;

   coreSequencer u_coreSequencer (
      .clk       (clk),
      .rstn      (rstn),
      .memVld    (memVld),
      .memRData  (memRData),
      .launch    (launch),
      .rd        (rd),
      .writesRd  (writesRd),
      .isLoad    (isLoad),
      .isStore   (isStore),
      .isHalt    (isHalt),
      .illegal   (illegal),
      .aluResult (aluResult),
      .rs2Data   (rs2Data),   // store data
      .memReq    (memReq),
      .memAddr   (memAddr),
      .memWEn    (memWEn),
      .memWData  (memWData),
      .halt      (halt),
      .instr     (instr),
      .rfWEn     (rfWEn),
      .rfWAddr   (rfWAddr),
      .rfWData   (rfWData)
   );

   instrDecoder u_instrDecoder (
      .instr    (instr),
      .rs1      (rs1),
      .rs2      (rs2),
      .rd       (rd),
      .imm      (imm),
      .useImm   (useImm),
      .aluOp    (aluOp),
      .writesRd (writesRd),
      .isLoad   (isLoad),
      .isStore  (isStore),
      .isHalt   (isHalt),
      .illegal  (illegal)
   );

   regFile u_regFile (
      .clk     (clk),
      .rstn    (rstn),
      .rs1     (rs1),
      .rs2     (rs2),
      .wEn     (rfWEn),
      .wAddr   (rfWAddr),
      .wData   (rfWData),
      .rs1Data (rs1Data),
      .rs2Data (rs2Data)
   );

   intAlu u_intAlu (
      .rs1Data (rs1Data),
      .rs2Data (rs2Data),
      .imm     (imm),
      .useImm  (useImm),
      .aluOp   (aluOp),
      .result  (aluResult)
   );

endmodule

// File: tb_rvCore.sv
`timescale 1ns/100ps
`include "rv_macros.svh"

module tb_rvCore;

   localparam int MemWords   = 1024;
   localparam int DataAddr   = 800;
   localparam int HaltLimit  = 600;   // cycles
   localparam int NumRows    = 18;

   typedef enum {tAdd, tSub, tXor, tOr, tAnd, tSll, tAddi, tSlti, tXori, tOri, tAndi,
                 tSlli, tSrli, tSrai, tLui} testOpE;

   logic                clk;
   logic                rstn;
   logic                memReq;
   logic [`RV_XLEN-1:0] memAddr;
   logic                memWEn;
   logic [`RV_XLEN-1:0] memWData;
   logic                memVld;
   logic [`RV_XLEN-1:0] memRData;
   logic                halt;
   logic                launch;

   logic [31:0] mem [MemWords];
   logic [31:0] lfsrState;
   logic [31:0] storeAddr [$];
   logic [31:0] storeData [$];
   bit          busy;
   int          waitCnt;
   int          progPc;
   int          passCount;
   int          failCount;

   testOpE      rowOp [NumRows];
   logic [31:0] rowA [NumRows];
   logic [31:0] rowB [NumRows];
   bit          rowRnd [NumRows];
   bit          rowFixed [NumRows];
   logic [31:0] rowExp [NumRows];
   int          rowCount;

   rvCore u_rvCore (
      .clk      (clk),
      .rstn     (rstn),
      .memReq   (memReq),
      .memAddr  (memAddr),
      .memWEn   (memWEn),
      .memWData (memWData),
      .memVld   (memVld),
      .memRData (memRData),
      .halt     (halt),
      .launch   (launch)
   );

   always #50 clk = ~clk;

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] randBits(input int n);
      logic [31:0] r;
      logic        fb;
      r = '0;
      for (int i = 0; i < n; i++) begin
         fb        = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
         lfsrState = {lfsrState[30:0], fb};
         r         = {r[30:0], fb};
      end
      return r;
   endfunction

   // memory answers after 0 to 3 idle cycles
   always @(negedge clk) begin
      if (memVld) begin
         memVld = 1'b0;   // transfer done at the last rising edge
      end else if (memReq) begin
         if (!busy) begin
            busy    = 1'b1;
            waitCnt = randBits(2);
         end
         if (waitCnt == 0) begin
            busy     = 1'b0;
            memVld   = 1'b1;
            memRData = mem[memAddr % MemWords];
            if (memWEn) begin
               mem[memAddr % MemWords] = memWData;
               storeAddr.push_back(memAddr);
               storeData.push_back(memWData);
            end
         end else begin
            waitCnt--;
         end
      end
   end

   function automatic logic [31:0] encR(input logic [6:0] f7, input logic [2:0] f3);
      return {f7, 5'd2, 5'd1, f3, 5'd3, 7'(rvPkg::opOp)};   // x3 = x1 op x2
   endfunction

   function automatic logic [31:0] encI(input logic [6:0] op, input logic [4:0] rd,
                                        input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [11:0] imm);
      return {imm, rs1, f3, rd, op};
   endfunction

   function automatic logic [31:0] encS(input logic [11:0] imm, input logic [4:0] rs2);
      return {imm[11:5], rs2, 5'd0, 3'b010, imm[4:0], 7'(rvPkg::opStore)};
   endfunction

   function automatic logic [31:0] encLui(input logic [19:0] imm, input logic [4:0] rd);
      return {imm, rd, 7'(rvPkg::opLui)};
   endfunction

   function automatic logic [31:0] opInstr(input testOpE op, input logic [31:0] b);
      logic [6:0] oi;
      oi = 7'(rvPkg::opOpImm);
      case (op)
         tAdd:    return encR(7'h00, 3'd0);
         tSub:    return encR(7'h20, 3'd0);
         tXor:    return encR(7'h00, 3'd4);
         tOr:     return encR(7'h00, 3'd6);
         tAnd:    return encR(7'h00, 3'd7);
         tSll:    return encR(7'h00, 3'd1);
         tAddi:   return encI(oi, 5'd3, 3'd0, 5'd1, b[11:0]);
         tSlti:   return encI(oi, 5'd3, 3'd2, 5'd1, b[11:0]);
         tXori:   return encI(oi, 5'd3, 3'd4, 5'd1, b[11:0]);
         tOri:    return encI(oi, 5'd3, 3'd6, 5'd1, b[11:0]);
         tAndi:   return encI(oi, 5'd3, 3'd7, 5'd1, b[11:0]);
         tSlli:   return encI(oi, 5'd3, 3'd1, 5'd1, {7'h00, b[4:0]});
         tSrli:   return encI(oi, 5'd3, 3'd5, 5'd1, {7'h00, b[4:0]});
         tSrai:   return encI(oi, 5'd3, 3'd5, 5'd1, {7'h20, b[4:0]});
         default: return encLui(b[19:0], 5'd3);
      endcase
   endfunction

   // expected value from the architectural rules
   function automatic logic [31:0] refResult(input testOpE op, input logic [31:0] a,
                                             input logic [31:0] b);
      logic [31:0] sImm;
      sImm = {{20{b[11]}}, b[11:0]};
      case (op)
         tAdd:    return a + b;
         tSub:    return a - b;
         tXor:    return a ^ b;
         tOr:     return a | b;
         tAnd:    return a & b;
         tSll:    return a << b[4:0];
         tAddi:   return a + sImm;
         tSlti:   return ($signed(a) < $signed(sImm)) ? 32'd1 : 32'd0;
         tXori:   return a ^ sImm;
         tOri:    return a | sImm;
         tAndi:   return a & sImm;
         tSlli:   return a << b[4:0];
         tSrli:   return a >> b[4:0];
         tSrai:   return $signed(a) >>> b[4:0];
         default: return {b[19:0], 12'h000};
      endcase
   endfunction

   task automatic addRow(input testOpE op, input logic [31:0] a, input logic [31:0] b,
                         input bit rnd, input bit fixedExp, input logic [31:0] exp);
      rowOp[rowCount]    = op;
      rowA[rowCount]     = a;
      rowB[rowCount]     = b;
      rowRnd[rowCount]   = rnd;
      rowFixed[rowCount] = fixedExp;
      rowExp[rowCount]   = exp;
      rowCount++;
   endtask

   task automatic putWord(input logic [31:0] w);
      mem[progPc] = w;
      progPc++;
   endtask

   task automatic loadImm(input logic [4:0] rd, input logic [31:0] v);
      logic [31:0] upper;
      upper = (v + 32'h800) >> 12;   // addi of the low part sign-extends
      putWord(encLui(upper[19:0], rd));
      putWord(encI(7'(rvPkg::opOpImm), rd, 3'd0, rd, v[11:0]));
   endtask

   task automatic launchCore();
      storeAddr.delete();
      storeData.delete();
      @(negedge clk);
      launch = 1'b1;
      @(negedge clk);
      launch = 1'b0;
   endtask

   task automatic waitHalt(output bit ok);
      int i;
      for (i = 0; i < HaltLimit && !halt; i++) begin
         @(negedge clk);
      end
      ok = halt;
      if (!ok) begin
         $display("core did not halt within %0d cycles", HaltLimit);
      end
   endtask

   task automatic checkStore(input string name, input bit ok, input logic [31:0] addr,
                             input logic [31:0] exp);
      bit good;
      good = ok;
      if (storeAddr.size() != 1) begin
         $display("error @%0t: %s saw %0d stores, expected 1", $time, name, storeAddr.size());
         good = 1'b0;
      end else if (storeAddr[0] != addr || storeData[0] !== exp) begin
         $display("error @%0t: %s stored %h at %0d, expected %h at %0d", $time, name,
                  storeData[0], storeAddr[0], exp, addr);
         good = 1'b0;
      end
      if (good) passCount++;
      else failCount++;
      $display("test %-10s %s", name, good ? "ok" : "bad");
   endtask

   task automatic checkIdle(input string name);
      bit good;
      good = 1'b1;
      for (int i = 0; i < 8 && good; i++) begin
         @(negedge clk);
         if (memReq !== 1'b0 || halt !== 1'b1) begin
            $display("error @%0t: %s core active while halted", $time, name);
            good = 1'b0;
         end
      end
      if (good) passCount++;
      else failCount++;
      $display("test %-10s %s", name, good ? "ok" : "bad");
   endtask

   initial begin
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] exp;
      bit          ok;
      bit          resetOk;

      clk = 1'b0;
      rstn = 1'b0;
      launch = 1'b0;
      memVld = 1'b0;
      memRData = '0;
      lfsrState = 32'h5444f8a8;
      busy = 1'b0;
      progPc = `RV_RESET_PC;
      passCount = 0;
      failCount = 0;
      rowCount = 0;
      resetOk = 1'b1;
      for (int i = 0; i < MemWords; i++) begin
         mem[i] = i * 32'h9e37_79b1;
      end

      addRow(tAdd,  0, 0, 1, 0, 0);
      addRow(tSub,  0, 0, 1, 0, 0);
      addRow(tXor,  0, 0, 1, 0, 0);
      addRow(tOr,   0, 0, 1, 0, 0);
      addRow(tAnd,  0, 0, 1, 0, 0);
      addRow(tSll,  0, 0, 1, 0, 0);
      addRow(tSub,  5, 7, 0, 1, 32'hffff_fffe);
      addRow(tAddi, 10, 32'hffd, 0, 1, 7);
      addRow(tAddi, -100, 32'h7ff, 0, 0, 0);
      addRow(tSlti, -5, 3, 0, 1, 1);
      addRow(tSlti, 5, 32'hfff, 0, 1, 0);
      addRow(tXori, 32'h0f0f_0f0f, 32'hfff, 0, 1, 32'hf0f0_f0f0);
      addRow(tOri,  32'h1200_0000, 32'h800, 0, 0, 0);
      addRow(tAndi, 32'h1234_5678, 32'h800, 0, 1, 32'h1234_5000);
      addRow(tSlli, 1, 31, 0, 1, 32'h8000_0000);
      addRow(tSrli, 32'h8000_0000, 4, 0, 1, 32'h0800_0000);
      addRow(tSrai, 32'h8000_0000, 4, 0, 1, 32'hf800_0000);
      addRow(tLui,  0, 32'habcde, 0, 1, 32'habcd_e000);

      // idle outputs through reset and until the first launch
      for (int i = 0; i < 20; i++) begin
         @(negedge clk);
         if (i == 15) rstn = 1'b1;
         if (i > 0 && (halt !== 1'b1 || memReq !== 1'b0 || memWEn !== 1'b0)) begin
            resetOk = 1'b0;
         end
      end
      if (!resetOk) begin
         $display("error @%0t: outputs not idle during or after reset", $time);
         failCount++;
      end else begin
         passCount++;
      end
      $display("test %-10s %s", "reset", resetOk ? "ok" : "bad");

      for (int r = 0; r < rowCount; r++) begin
         a = rowRnd[r] ? randBits(32) : rowA[r];
         b = rowRnd[r] ? randBits(32) : rowB[r];
         exp = rowFixed[r] ? rowExp[r] : refResult(rowOp[r], a, b);
         loadImm(5'd1, a);
         loadImm(5'd2, b);
         putWord(opInstr(rowOp[r], b));
         putWord(encS(12'(DataAddr), 5'd3));
         putWord({25'h0, `RV_HALT_OPCODE});
         launchCore();
         waitHalt(ok);
         checkStore(rowOp[r].name(), ok, DataAddr, exp);
      end

      // load a preset word and store it elsewhere
      mem[810] = 32'hc0ff_ee11;
      putWord(encI(7'(rvPkg::opLoad), 5'd4, 3'b010, 5'd0, 12'd810));
      putWord(encS(12'd811, 5'd4));
      putWord({25'h0, `RV_HALT_OPCODE});
      launchCore();
      waitHalt(ok);
      checkStore("lw_sw", ok, 811, 32'hc0ff_ee11);

      // x0 stays zero
      putWord(encI(7'(rvPkg::opOpImm), 5'd0, 3'd0, 5'd0, 12'd123));
      putWord(encS(12'd812, 5'd0));
      putWord({25'h0, `RV_HALT_OPCODE});
      launchCore();
      waitHalt(ok);
      checkStore("x0", ok, 812, 32'h0);

      // illegal word halts and launch resumes after it
      loadImm(5'd3, 32'h5a5a_1234);
      putWord(32'h0000_0000);
      putWord(encS(12'd813, 5'd3));
      putWord({25'h0, `RV_HALT_OPCODE});
      launchCore();
      waitHalt(ok);
      if (storeAddr.size() != 0) begin
         $display("error @%0t: store seen before the illegal word halted", $time);
         failCount++;
      end
      checkIdle("illegal");
      launchCore();
      waitHalt(ok);
      checkIdle("halt");
      checkStore("resume", ok, 813, 32'h5a5a_1234);

      $display("%0d tests passed, %0d failed", passCount, failCount);
      if (failCount == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

// File: rvCore.f
+incdir+.
rvPkg.sv
regFile.sv
intAlu.sv
instrDecoder.sv
coreSequencer.sv
rvCore.sv
tb_rvCore.sv

// File: Bender.yml
package:
  name: rvCore

export_include_dirs:
  - .

sources:
  - files:
      - rvPkg.sv
      - regFile.sv
      - intAlu.sv
      - instrDecoder.sv
      - coreSequencer.sv
      - rvCore.sv
  - target: test
    files:
      - tb_rvCore.sv
